// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f vlog.f --top-module llc_mshr_tb -o llc_mshr_sim
./obj_dir/llc_mshr_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// ==== src/llc_mshr.sv ====
module llc_mshr #(
    parameter int N_MSHR = 4,
    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1
) (
    input  logic                                      clk,
    input  logic                                      rst,
    // allocate the entry at idx_o
    input  logic                                      add_entry_i,
    // single-field updates at idx_o
    input  llc_mshr_pkg::mshr_wr_en_t                 wr_en_i,
    // values for allocation and updates
    input  llc_mshr_pkg::mshr_update_t                upd_i,
    // search to run this cycle
    input  llc_mshr_pkg::mshr_op_e                    op_i,
    // incoming line
    input  llc_mshr_pkg::line_addr_t                  line_addr_i,
    // set conflict triggers for the llc fsm
    output logic                                      set_conflict_set_o,
    output logic                                      set_conflict_clr_o,
    // combinational search result
    output logic                                      hit_next_o,
    output logic [IDX_W-1:0]                          idx_next_o,
    // registered search result, also the write target
    output logic                                      hit_o,
    output logic [IDX_W-1:0]                          idx_o,
    // every entry, for the fsm and datapath
    output llc_mshr_pkg::mshr_entry_t [N_MSHR-1:0]    entries_o
);

    import llc_mshr_pkg::*;

    // entry registers
    // writes land on the index kept by the search
    mshr_store #(
        .N_MSHR      (N_MSHR)
    ) i_store (
        .clk         (clk),
        .rst         (rst),
        .add_entry_i (add_entry_i),
        .wr_en_i     (wr_en_i),
        .upd_i       (upd_i),
        .set_i       (line_addr_i.set),
        .idx_i       (idx_o),
        .entries_o   (entries_o)
    );

    // lookup and peek over the stored entries
    mshr_search #(
        .N_MSHR             (N_MSHR)
    ) i_search (
        .clk                (clk),
        .rst                (rst),
        .op_i               (op_i),
        .line_addr_i        (line_addr_i),
        .entries_i          (entries_o),
        .hit_next_o         (hit_next_o),
        .idx_next_o         (idx_next_o),
        .hit_o              (hit_o),
        .idx_o              (idx_o),
        .set_conflict_set_o (set_conflict_set_o),
        .set_conflict_clr_o (set_conflict_clr_o)
    );

endmodule

// ==== src/llc_mshr_pkg.sv ====
package llc_mshr_pkg;

    // address breakdown of a line in the llc
    localparam int TAG_W = 8;
    localparam int SET_W = 4;
    localparam int WAY_W = 2;

    // line payload and its per-word mask
    localparam int LINE_W         = 64;
    localparam int WORDS_PER_LINE = 4;

    // small control fields carried with each miss
    localparam int MSG_W      = 2;
    localparam int CACHE_ID_W = 4;
    localparam int HPROT_W    = 2;
    localparam int INVACK_W   = 4;
    localparam int STATE_W    = 3;

    // field types
    typedef logic [TAG_W-1:0]          llc_tag_t;
    typedef logic [SET_W-1:0]          llc_set_t;
    typedef logic [WAY_W-1:0]          llc_way_t;
    typedef logic [LINE_W-1:0]         line_t;
    typedef logic [WORDS_PER_LINE-1:0] word_mask_t;

    typedef logic [MSG_W-1:0]      mix_msg_t;
    typedef logic [CACHE_ID_W-1:0] cache_id_t;
    typedef logic [HPROT_W-1:0]    hprot_t;
    typedef logic [INVACK_W-1:0]   invack_cnt_t;

    // transient coherence state of an outstanding miss
    typedef logic [STATE_W-1:0] unstable_state_t;

    // invalid state, an entry holding it is free
    localparam unstable_state_t LLC_I = '0;

    // incoming line address, tag above set
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_addr_t;

    // one outstanding miss
    typedef struct packed {
        mix_msg_t        msg;
        cache_id_t       req_id;
        llc_tag_t        tag;
        llc_set_t        set;
        llc_way_t        way;
        unstable_state_t state;
        hprot_t          hprot;
        invack_cnt_t     invack_cnt;
        line_t           line;
        word_mask_t      word_mask;
        // mask kept aside for the requester
        word_mask_t      word_mask_reg;
    } mshr_entry_t;

    // write values for an entry
    // set is missing on purpose, it is taken from the line address
    typedef struct packed {
        mix_msg_t        msg;
        cache_id_t       req_id;
        llc_tag_t        tag;
        llc_way_t        way;
        unstable_state_t state;
        hprot_t          hprot;
        invack_cnt_t     invack_cnt;
        line_t           line;
        word_mask_t      word_mask;
        word_mask_t      word_mask_reg;
    } mshr_update_t;

    // per-field write strobes for an existing entry
    typedef struct packed {
        logic state;
        logic line;
        logic tag;
        logic word_mask;
        logic invack_cnt;
    } mshr_wr_en_t;

    // search operation requested by the llc fsm
    typedef enum logic [1:0] {
        MSHR_IDLE     = 2'd0,
        MSHR_LOOKUP   = 2'd1,
        MSHR_PEEK_REQ = 2'd2
    } mshr_op_e;

endpackage

// ==== src/mshr_search.sv ====
module mshr_search #(
    parameter int N_MSHR = 4,
    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  llc_mshr_pkg::mshr_op_e                    op_i,
    input  llc_mshr_pkg::line_addr_t                  line_addr_i,
    input  llc_mshr_pkg::mshr_entry_t [N_MSHR-1:0]    entries_i,
    // same-cycle search result
    output logic                                      hit_next_o,
    output logic [IDX_W-1:0]                          idx_next_o,
    // result of the last non-idle search
    output logic                                      hit_o,
    output logic [IDX_W-1:0]                          idx_o,
    // set conflict triggers, peek only
    output logic                                      set_conflict_set_o,
    output logic                                      set_conflict_clr_o
);

    import llc_mshr_pkg::*;

    // per-entry match vectors
    logic [N_MSHR-1:0] valid;
    logic [N_MSHR-1:0] addr_match;
    logic [N_MSHR-1:0] set_match;

    always_comb begin
        for (int i = 0; i < N_MSHR; i++) begin
            valid[i]      = (entries_i[i].state != LLC_I);
            // same set, any tag
            set_match[i]  = valid[i] && (entries_i[i].set == line_addr_i.set);
            // same set and tag
            addr_match[i] = set_match[i] && (entries_i[i].tag == line_addr_i.tag);
        end
    end

    always_comb begin
        hit_next_o         = 1'b0;
        idx_next_o         = '0;
        set_conflict_set_o = 1'b0;
        set_conflict_clr_o = 1'b0;

        case (op_i)
            // find the entry owning this line
            MSHR_LOOKUP: begin
                // ascending scan, highest index ends up winning
                for (int i = 0; i < N_MSHR; i++) begin
                    if (addr_match[i]) begin
                        hit_next_o = 1'b1;
                        idx_next_o = IDX_W'(i);
                    end
                end
            end
            // pick a free slot and check the set
            MSHR_PEEK_REQ: begin
                for (int i = 0; i < N_MSHR; i++) begin
                    if (!valid[i]) begin
                        idx_next_o = IDX_W'(i);
                    end
                end
                // any live miss in this set stalls the request
                set_conflict_set_o = |set_match;
                set_conflict_clr_o = ~|set_match;
            end
            default: begin
                // idle, all outputs stay zero
                hit_next_o = 1'b0;
            end
        endcase
    end

    // keep the result for the allocate or update that follows
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_o <= 1'b0;
            idx_o <= '0;
        end else if (op_i != MSHR_IDLE) begin
            hit_o <= hit_next_o;
            idx_o <= idx_next_o;
        end
    end

endmodule

// ==== src/mshr_store.sv ====
module mshr_store #(
    parameter int N_MSHR = 4,
    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1
) (
    input  logic                                      clk,
    input  logic                                      rst,
    // full allocation of the selected entry
    input  logic                                      add_entry_i,
    // single-field rewrites of the selected entry
    input  llc_mshr_pkg::mshr_wr_en_t                 wr_en_i,
    input  llc_mshr_pkg::mshr_update_t                upd_i,
    // set of the incoming line
    input  llc_mshr_pkg::llc_set_t                    set_i,
    // write target, from the registered search index
    input  logic [IDX_W-1:0]                          idx_i,
    output llc_mshr_pkg::mshr_entry_t [N_MSHR-1:0]    entries_o
);

    import llc_mshr_pkg::*;

    // one register group per entry
    for (genvar i = 0; i < N_MSHR; i++) begin : g_entry
        logic            sel;
        mix_msg_t        msg_q;
        cache_id_t       req_id_q;
        llc_tag_t        tag_q;
        llc_set_t        set_q;
        llc_way_t        way_q;
        unstable_state_t state_q;
        hprot_t          hprot_q;
        invack_cnt_t     invack_cnt_q;
        line_t           line_q;
        word_mask_t      word_mask_q;
        word_mask_t      word_mask_reg_q;

        // this entry is the write target
        assign sel = (idx_i == IDX_W'(i));

        // fields only written at allocation
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                msg_q           <= '0;
                req_id_q        <= '0;
                set_q           <= '0;
                way_q           <= '0;
                hprot_q         <= '0;
                word_mask_reg_q <= '0;
            end else if (sel && add_entry_i) begin
                msg_q           <= upd_i.msg;
                req_id_q        <= upd_i.req_id;
                // set comes from the address, not the update
                set_q           <= set_i;
                way_q           <= upd_i.way;
                hprot_q         <= upd_i.hprot;
                word_mask_reg_q <= upd_i.word_mask_reg;
            end
        end

        // state, back to LLC_I frees the slot
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                state_q <= LLC_I;
            end else if (sel && (add_entry_i || wr_en_i.state)) begin
                state_q <= upd_i.state;
            end
        end

        // line data
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                line_q <= '0;
            end else if (sel && (add_entry_i || wr_en_i.line)) begin
                line_q <= upd_i.line;
            end
        end

        // tag
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                tag_q <= '0;
            end else if (sel && (add_entry_i || wr_en_i.tag)) begin
                tag_q <= upd_i.tag;
            end
        end

        // word mask of the pending line
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                word_mask_q <= '0;
            end else if (sel && (add_entry_i || wr_en_i.word_mask)) begin
                word_mask_q <= upd_i.word_mask;
            end
        end

        // outstanding invalidation acks
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                invack_cnt_q <= '0;
            end else if (sel && (add_entry_i || wr_en_i.invack_cnt)) begin
                invack_cnt_q <= upd_i.invack_cnt;
            end
        end

        // pack fields back into the entry view
        assign entries_o[i] = mshr_entry_t'{
            msg:           msg_q,
            req_id:        req_id_q,
            tag:           tag_q,
            set:           set_q,
            way:           way_q,
            state:         state_q,
            hprot:         hprot_q,
            invack_cnt:    invack_cnt_q,
            line:          line_q,
            word_mask:     word_mask_q,
            word_mask_reg: word_mask_reg_q
        };
    end

endmodule

// ==== test/llc_mshr_assertions.sv ====
module llc_mshr_assertions #(
    parameter int N_MSHR = 4,
    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1
) (
    input logic                                   clk,
    input logic                                   rst,
    input logic                                   add_entry_i,
    input llc_mshr_pkg::mshr_wr_en_t              wr_en_i,
    input llc_mshr_pkg::mshr_update_t             upd_i,
    input llc_mshr_pkg::mshr_op_e                 op_i,
    input llc_mshr_pkg::line_addr_t               line_addr_i,
    // dut outputs, observed only
    input logic                                   conflict_set_i,
    input logic                                   conflict_clr_i,
    input logic                                   hit_next_i,
    input logic [IDX_W-1:0]                       idx_next_i,
    input logic                                   hit_i,
    input logic [IDX_W-1:0]                       idx_i,
    input llc_mshr_pkg::mshr_entry_t [N_MSHR-1:0] entries_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import llc_mshr_pkg::*;

    // failed assertions so far
    int fail_cnt = 0;

    // expected search results over the stored entries
    logic             any_valid;
    logic             exp_hit;
    logic [IDX_W-1:0] exp_hit_idx;
    logic             exp_conflict;
    logic             free_seen;
    logic [IDX_W-1:0] exp_free_idx;
    // entry file expected after the next edge
    mshr_entry_t [N_MSHR-1:0] exp_next;
    // copies taken at the previous edge
    mshr_entry_t [N_MSHR-1:0] exp_q;
    logic             busy_q;
    logic             hit_next_q;
    logic [IDX_W-1:0] idx_next_q;
    logic             hit_q;
    logic [IDX_W-1:0] idx_q;

    always_comb begin
        any_valid    = 1'b0;
        exp_hit      = 1'b0;
        exp_hit_idx  = '0;
        exp_conflict = 1'b0;
        free_seen    = 1'b0;
        exp_free_idx = '0;
        // walk down, first find is the highest index
        for (int i = N_MSHR - 1; i >= 0; i--) begin
            if (entries_i[i].state == LLC_I) begin
                if (!free_seen) begin
                    free_seen    = 1'b1;
                    exp_free_idx = IDX_W'(i);
                end
            end else begin
                any_valid = 1'b1;
                // same set is a conflict whatever the tag
                if (entries_i[i].set == line_addr_i.set) begin
                    exp_conflict = 1'b1;
                    if (!exp_hit && entries_i[i].tag == line_addr_i.tag) begin
                        exp_hit     = 1'b1;
                        exp_hit_idx = IDX_W'(i);
                    end
                end
            end
        end
    end

    always_comb begin
        exp_next = entries_i;
        if (add_entry_i) begin
            // whole entry, set from the line address
            exp_next[idx_i] = {upd_i.msg, upd_i.req_id, upd_i.tag, line_addr_i.set, upd_i.way,
                               upd_i.state, upd_i.hprot, upd_i.invack_cnt, upd_i.line,
                               upd_i.word_mask, upd_i.word_mask_reg};
        end else begin
            // only the strobed fields move
            if (wr_en_i.state) exp_next[idx_i].state = upd_i.state;
            if (wr_en_i.line) exp_next[idx_i].line = upd_i.line;
            if (wr_en_i.tag) exp_next[idx_i].tag = upd_i.tag;
            if (wr_en_i.word_mask) exp_next[idx_i].word_mask = upd_i.word_mask;
            if (wr_en_i.invack_cnt) exp_next[idx_i].invack_cnt = upd_i.invack_cnt;
        end
    end

    always_ff @(posedge clk) begin
        exp_q      <= exp_next;
        busy_q     <= (op_i != MSHR_IDLE);
        hit_next_q <= hit_next_i;
        idx_next_q <= idx_next_i;
        hit_q      <= hit_i;
        idx_q      <= idx_i;
    end

    // reset frees every entry and clears the result
    a_reset: assert property (@(posedge clk) !rst |-> !hit_i && idx_i == '0 && !any_valid)
        else begin
            $error("FAIL %0t hit_o/idx_o/valid exp 0/0/0 got %0d/%0d/%0d",
                   $time, hit_i, idx_i, any_valid);
            fail_cnt++;
        end

    // allocation and field writes land one cycle later, nothing else moves
    a_entries: assert property (@(posedge clk) disable iff (!rst) entries_i == exp_q)
        else begin
            $error("FAIL %0t entries_o exp %h got %h", $time, exp_q, entries_i);
            fail_cnt++;
        end

    a_lookup: assert property (@(posedge clk) disable iff (!rst)
        op_i == MSHR_LOOKUP |-> hit_next_i == exp_hit && (!exp_hit || idx_next_i == exp_hit_idx))
        else begin
            $error("FAIL %0t hit_next_o/idx_next_o exp %0d/%0d got %0d/%0d",
                   $time, exp_hit, exp_hit_idx, hit_next_i, idx_next_i);
            fail_cnt++;
        end

    a_peek: assert property (@(posedge clk) disable iff (!rst)
        op_i == MSHR_PEEK_REQ |-> conflict_set_i == exp_conflict
            && conflict_clr_i == !exp_conflict && idx_next_i == exp_free_idx)
        else begin
            $error("FAIL %0t set_conflict_set_o/clr_o/idx_next_o exp %0d/%0d/%0d got %0d/%0d/%0d",
                   $time, exp_conflict, !exp_conflict, exp_free_idx,
                   conflict_set_i, conflict_clr_i, idx_next_i);
            fail_cnt++;
        end

    // registered result follows a non-idle search
    a_result: assert property (@(posedge clk) disable iff (!rst)
        busy_q |-> hit_i == hit_next_q && idx_i == idx_next_q)
        else begin
            $error("FAIL %0t hit_o/idx_o exp %0d/%0d got %0d/%0d",
                   $time, hit_next_q, idx_next_q, hit_i, idx_i);
            fail_cnt++;
        end

    a_idle_out: assert property (@(posedge clk) disable iff (!rst)
        op_i == MSHR_IDLE |-> !hit_next_i && idx_next_i == '0 && !conflict_set_i && !conflict_clr_i)
        else begin
            $error("FAIL %0t hit_next_o/idx_next_o/set/clr exp 0/0/0/0 got %0d/%0d/%0d/%0d",
                   $time, hit_next_i, idx_next_i, conflict_set_i, conflict_clr_i);
            fail_cnt++;
        end

    // idle keeps the last result
    a_idle_hold: assert property (@(posedge clk) disable iff (!rst)
        !busy_q |-> hit_i == hit_q && idx_i == idx_q)
        else begin
            $error("FAIL %0t hit_o/idx_o exp %0d/%0d got %0d/%0d", $time, hit_q, idx_q, hit_i, idx_i);
            fail_cnt++;
        end

endmodule

bind llc_mshr llc_mshr_assertions #(
    .N_MSHR         (N_MSHR)
) i_chk (
    .clk            (clk),
    .rst            (rst),
    .add_entry_i    (add_entry_i),
    .wr_en_i        (wr_en_i),
    .upd_i          (upd_i),
    .op_i           (op_i),
    .line_addr_i    (line_addr_i),
    .conflict_set_i (set_conflict_set_o),
    .conflict_clr_i (set_conflict_clr_o),
    .hit_next_i     (hit_next_o),
    .idx_next_i     (idx_next_o),
    .hit_i          (hit_o),
    .idx_i          (idx_o),
    .entries_i      (entries_o)
);

// ==== test/llc_mshr_tb.sv ====
module llc_mshr_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import llc_mshr_pkg::*;

    localparam int N_MSHR = 4;
    localparam int IDX_W  = $clog2(N_MSHR);
    // 200 cycles of 40 ns
    localparam time LIMIT = 200 * 40;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     add_entry;
    mshr_wr_en_t              wr_en;
    mshr_update_t             upd;
    mshr_op_e                 op;
    line_addr_t               line_addr;
    logic                     conflict_set;
    logic                     conflict_clr;
    logic                     hit_next;
    logic [IDX_W-1:0]         idx_next;
    logic                     hit;
    logic [IDX_W-1:0]         idx;
    mshr_entry_t [N_MSHR-1:0] entries;

    // address pool, 0 and 2 share a set
    line_addr_t  addrs [4];
    logic [31:0] lfsr = 32'h05ee18a3;
    int          errors;

    llc_mshr #(
        .N_MSHR             (N_MSHR)
    ) i_dut (
        .clk                (clk),
        .rst                (rst),
        .add_entry_i        (add_entry),
        .wr_en_i            (wr_en),
        .upd_i              (upd),
        .op_i               (op),
        .line_addr_i        (line_addr),
        .set_conflict_set_o (conflict_set),
        .set_conflict_clr_o (conflict_clr),
        .hit_next_o         (hit_next),
        .idx_next_o         (idx_next),
        .hit_o              (hit),
        .idx_o              (idx),
        .entries_o          (entries)
    );

    always #20 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[62:0], next_bit()};
        return v;
    endfunction

    function automatic mshr_update_t rand_upd(input logic valid);
        mshr_update_t u;
        u.msg           = mix_msg_t'(rand_bits(MSG_W));
        u.req_id        = cache_id_t'(rand_bits(CACHE_ID_W));
        u.tag           = llc_tag_t'(rand_bits(TAG_W));
        u.way           = llc_way_t'(rand_bits(WAY_W));
        u.state         = unstable_state_t'(rand_bits(STATE_W));
        u.hprot         = hprot_t'(rand_bits(HPROT_W));
        u.invack_cnt    = invack_cnt_t'(rand_bits(INVACK_W));
        u.line          = line_t'(rand_bits(LINE_W));
        u.word_mask     = word_mask_t'(rand_bits(WORDS_PER_LINE));
        u.word_mask_reg = word_mask_t'(rand_bits(WORDS_PER_LINE));
        // a live miss needs a state other than LLC_I
        if (valid && u.state == LLC_I)
            u.state = unstable_state_t'(1);
        return u;
    endfunction

    task automatic apply(input mshr_op_e o, input line_addr_t a, input logic add,
                         input mshr_wr_en_t w, input mshr_update_t u);
        @(posedge clk);
        op        <= o;
        line_addr <= a;
        add_entry <= add;
        wr_en     <= w;
        upd       <= u;
    endtask

    initial begin
        mshr_update_t u;
        mshr_wr_en_t  w;
        line_addr_t   a;
        logic [1:0]   r;

        rst       <= 1'b0;
        add_entry <= 1'b0;
        wr_en     <= '0;
        upd       <= '0;
        op        <= MSHR_IDLE;
        line_addr <= '0;
        addrs[0] = line_addr_t'(rand_bits(TAG_W + SET_W));
        addrs[1] = line_addr_t'(rand_bits(TAG_W + SET_W));
        addrs[2].tag = ~addrs[0].tag;
        addrs[2].set = addrs[0].set;
        addrs[3] = line_addr_t'(rand_bits(TAG_W + SET_W));
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        // peek then allocate, first peek sees the empty file
        for (int k = 0; k < 3; k++) begin
            u     = rand_upd(1'b1);
            u.tag = addrs[k].tag;
            apply(MSHR_PEEK_REQ, addrs[k], 1'b0, '0, '0);
            apply(MSHR_IDLE, addrs[k], 1'b1, '0, u);
        end
        // hits, then a miss
        for (int k = 0; k < 4; k++)
            apply(MSHR_LOOKUP, addrs[k], 1'b0, '0, '0);
        apply(MSHR_IDLE, addrs[3], 1'b0, '0, '0);
        apply(MSHR_IDLE, addrs[0], 1'b0, '0, '0);

        // one strobe per cycle on the slot of addrs[1]
        apply(MSHR_LOOKUP, addrs[1], 1'b0, '0, '0);
        for (int s = 0; s < 5; s++)
            apply(MSHR_IDLE, addrs[1], 1'b0, mshr_wr_en_t'(5'b1 << s), rand_upd(1'b1));

        // free the slot of addrs[0], next lookup misses
        w       = '0;
        w.state = 1'b1;
        apply(MSHR_LOOKUP, addrs[0], 1'b0, '0, '0);
        apply(MSHR_IDLE, addrs[0], 1'b0, w, '0);
        apply(MSHR_LOOKUP, addrs[0], 1'b0, '0, '0);

        // allocate with every strobe up as well
        u     = rand_upd(1'b1);
        u.tag = addrs[3].tag;
        apply(MSHR_PEEK_REQ, addrs[3], 1'b0, '0, '0);
        apply(MSHR_IDLE, addrs[3], 1'b1, '1, u);

        // random mix over the pool
        for (int k = 0; k < 40; k++) begin
            r     = 2'(rand_bits(2));
            a     = addrs[2'(rand_bits(2))];
            w     = (rand_bits(2) == 0) ? mshr_wr_en_t'(rand_bits(5)) : '0;
            u     = rand_upd(rand_bits(1) != 0);
            u.tag = a.tag;
            apply((r == 2'd3) ? MSHR_LOOKUP : mshr_op_e'(r), a, rand_bits(2) == 0, w, u);
        end
        apply(MSHR_IDLE, addrs[0], 1'b0, '0, '0);
        apply(MSHR_IDLE, addrs[0], 1'b0, '0, '0);
        @(posedge clk);
        #1;

        errors = i_dut.i_chk.fail_cnt;
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT);
        $display("timeout: stimulus still running after %0t", LIMIT);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/llc_mshr_pkg.sv
src/mshr_store.sv
src/mshr_search.sv
src/llc_mshr.sv
test/llc_mshr_assertions.sv
test/llc_mshr_tb.sv
